// ==== design/legv8_pkg.sv ====
`default_nettype none

package legv8_pkg;
	// Bus and register widths
	localparam int DATA_WIDTH = 64;
	localparam int ADDR_WIDTH = 32;
	localparam int CW_WIDTH = 34;
	localparam int REG_SEL_WIDTH = 5;
	localparam int FS_WIDTH = 5;

	// Data bus sources
	localparam logic [1:0] DS_ALU = 2'd0;
	localparam logic [1:0] DS_B = 2'd1;
	localparam logic [1:0] DS_PC = 2'd2;
	localparam logic [1:0] DS_MEM = 2'd3;

	// Address bus sources
	localparam logic AS_ALU = 1'b0;
	localparam logic AS_PC = 1'b1;

	// PC modes
	localparam logic [1:0] PS_HOLD = 2'd0;
	localparam logic [1:0] PS_INC = 2'd1;
	localparam logic [1:0] PS_JUMP = 2'd2;
	localparam logic [1:0] PS_BRANCH = 2'd3;

	// Memory access sizes
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;
	localparam logic [1:0] SIZE_DOUBLE = 2'd3;

	// ALU operations, fs[4:2]
	localparam logic [2:0] FN_AND = 3'd0;
	localparam logic [2:0] FN_OR = 3'd1;
	localparam logic [2:0] FN_ADD = 3'd2;
	localparam logic [2:0] FN_XOR = 3'd3;
	localparam logic [2:0] FN_LSL = 3'd4;
	localparam logic [2:0] FN_LSR = 3'd5;

	// Low address bits cleared to align an access
	function automatic logic [2:0] size_mask(input logic [1:0] size);
		case (size)
			SIZE_BYTE: return 3'b000;
			SIZE_HALF: return 3'b001;
			SIZE_WORD: return 3'b011;
			default: return 3'b111;
		endcase
	endfunction

	// Keep only the bytes of the access, upper bytes zero
	function automatic logic [DATA_WIDTH-1:0] zero_extend(input logic [DATA_WIDTH-1:0] value,
		input logic [1:0] size);
		case (size)
			SIZE_BYTE: return {56'd0, value[7:0]};
			SIZE_HALF: return {48'd0, value[15:0]};
			SIZE_WORD: return {32'd0, value[31:0]};
			default: return value;
		endcase
	endfunction
endpackage

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import legv8_pkg::*; (
	input logic clock,
	input logic reset,
	input logic rw,
	input logic [REG_SEL_WIDTH-1:0] da,
	input logic [REG_SEL_WIDTH-1:0] sa,
	input logic [REG_SEL_WIDTH-1:0] sb,
	input logic [DATA_WIDTH-1:0] write_value,
	output logic [DATA_WIDTH-1:0] a_value,
	output logic [DATA_WIDTH-1:0] b_value,
	output logic [7:0][15:0] view
);
	// XZR, hardwired zero
	localparam logic [REG_SEL_WIDTH-1:0] ZERO_REG = 5'd31;

	// Only X0..X30 have storage
	logic [DATA_WIDTH-1:0] regs [0:30];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 31; i++) begin
				regs[i] <= '0;
			end
		end else if (rw && da != ZERO_REG) begin
			// Writes to XZR are dropped
			regs[da] <= write_value;
		end
	end

	// Two combinational read ports
	assign a_value = (sa == ZERO_REG) ? '0 : regs[sa];
	assign b_value = (sb == ZERO_REG) ? '0 : regs[sb];

	// Low halves of X0..X7 for display
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			view[i] = regs[i][15:0];
		end
	end
endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import legv8_pkg::*; (
	input logic [DATA_WIDTH-1:0] a,
	input logic [DATA_WIDTH-1:0] b,
	input logic [FS_WIDTH-1:0] fs,
	input logic c0,
	output logic [DATA_WIDTH-1:0] result,
	output logic [3:0] flags
);
	localparam int SHIFT_BITS = $clog2(DATA_WIDTH);

	logic [DATA_WIDTH-1:0] a_in;
	logic [DATA_WIDTH-1:0] b_in;
	logic [DATA_WIDTH-1:0] sum;
	logic carry;
	logic overflow;
	logic c_flag;
	logic v_flag;

	// Optional operand inversion, used for SUB and NOT forms
	assign a_in = fs[1] ? ~a : a;
	assign b_in = fs[0] ? ~b : b;

	// Adder with carry-in, carry out in the extra bit
	assign {carry, sum} = {1'b0, a_in} + {1'b0, b_in} + {{DATA_WIDTH{1'b0}}, c0};
	// Signed overflow when like signs give an unlike sum
	assign overflow = (a_in[DATA_WIDTH-1] == b_in[DATA_WIDTH-1]) &&
		(sum[DATA_WIDTH-1] != a_in[DATA_WIDTH-1]);

	always_comb begin
		result = '0;
		c_flag = 1'b0;
		v_flag = 1'b0;
		case (fs[4:2])
			FN_AND: result = a_in & b_in;
			FN_OR: result = a_in | b_in;
			FN_ADD: begin
				result = sum;
				c_flag = carry;
				v_flag = overflow;
			end
			FN_XOR: result = a_in ^ b_in;
			// Shift amount from low bits of B
			FN_LSL: result = a_in << b_in[SHIFT_BITS-1:0];
			FN_LSR: result = a_in >> b_in[SHIFT_BITS-1:0];
			// Unused codes give zero
			default: result = '0;
		endcase
	end

	// V C N Z
	assign flags = {v_flag, c_flag, result[DATA_WIDTH-1], result == '0};
endmodule

`default_nettype wire

// ==== design/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter import legv8_pkg::*; #(
	parameter logic [ADDR_WIDTH-1:0] RESET_VALUE = '0
) (
	input logic clock,
	input logic reset,
	input logic [1:0] ps,
	input logic [ADDR_WIDTH-1:0] jump_target,
	input logic [ADDR_WIDTH-1:0] offset,
	output logic [ADDR_WIDTH-1:0] pc
);
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= RESET_VALUE;
		end else begin
			case (ps)
				PS_HOLD: pc <= pc;
				PS_INC: pc <= pc + 32'd4;
				// Register jump for BR
				PS_JUMP: pc <= jump_target;
				// Word offset scaled to bytes
				PS_BRANCH: pc <= pc + (offset << 2);
				default: pc <= pc;
			endcase
		end
	end

	// Sequential fetch needs a word aligned PC
	assert property (@(posedge clock) disable iff (reset)
		(ps == PS_INC) |-> (pc[1:0] == 2'b00))
		else $error("PC not word aligned on increment, pc=%h", pc);
endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory import legv8_pkg::*; #(
	parameter logic [legv8_pkg::ADDR_WIDTH-1:0] BASE_ADDR = 32'h2000_0000,
	parameter int ADDR_WIDTH = 10,
	parameter logic [legv8_pkg::ADDR_WIDTH-1:0] ROM_BASE = 32'h0000_0000,
	parameter int ROM_ADDR_WIDTH = 8
) (
	input logic clock,
	input logic [legv8_pkg::ADDR_WIDTH-1:0] address,
	input logic [DATA_WIDTH-1:0] write_data,
	input logic mw,
	input logic [1:0] size,
	output logic [DATA_WIDTH-1:0] read_data
);
	logic [legv8_pkg::ADDR_WIDTH-1:0] offset;
	logic in_window;
	logic [ADDR_WIDTH-1:0] local_addr;
	logic [ADDR_WIDTH-4:0] dword;
	logic [2:0] lane;
	logic [7:0] byte_en;
	logic [DATA_WIDTH-1:0] write_lanes;
	logic [DATA_WIDTH-1:0] raw;
	// Byte array, little endian
	logic [7:0] mem [0:2**ADDR_WIDTH-1];

	// Below base wraps to a large offset, so one compare covers both ends
	assign offset = address - BASE_ADDR;
	assign in_window = (offset >> ADDR_WIDTH) == '0;
	// Aligned down to the access size
	assign local_addr = offset[ADDR_WIDTH-1:0] & ~ADDR_WIDTH'(size_mask(size));
	assign dword = local_addr[ADDR_WIDTH-1:3];
	assign lane = local_addr[2:0];

	// Byte enables from size, moved to the starting lane
	assign byte_en = (8'hff >> (3'd7 - size_mask(size))) << lane;
	assign write_lanes = write_data << {lane, 3'b000};

	always_ff @(posedge clock) begin
		if (mw && in_window) begin
			for (int i = 0; i < 8; i++) begin
				if (byte_en[i]) begin
					mem[{dword, 3'(i)}] <= write_lanes[8*i +: 8];
				end
			end
		end
	end

	// Whole doubleword, then shift the wanted bytes down
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			raw[8*i +: 8] = mem[{dword, 3'(i)}];
		end
	end

	assign read_data = in_window ? zero_extend(raw >> {lane, 3'b000}, size) : '0;

	// Stores into the ROM window are not allowed
	assert property (@(posedge clock) mw |-> ((address - ROM_BASE) >> ROM_ADDR_WIDTH) != '0)
		else $error("RAM write inside ROM window at %h", address);
endmodule

`default_nettype wire

// ==== design/instruction_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_rom import legv8_pkg::*; #(
	parameter logic [legv8_pkg::ADDR_WIDTH-1:0] BASE_ADDR = 32'h0000_0000,
	parameter int ADDR_WIDTH = 8
) (
	input logic [legv8_pkg::ADDR_WIDTH-1:0] address,
	input logic [1:0] size,
	output logic [DATA_WIDTH-1:0] read_data
);
	logic [legv8_pkg::ADDR_WIDTH-1:0] offset;
	logic in_window;
	logic [ADDR_WIDTH-1:0] local_addr;
	logic [DATA_WIDTH-1:0] word;
	// Doubleword storage, byte 0 in the low bits
	logic [DATA_WIDTH-1:0] words [0:2**(ADDR_WIDTH-3)-1];

	initial begin
		$readmemh("verification/rom_image.hex", words);
	end

	// Window check and alignment, as in the RAM
	assign offset = address - BASE_ADDR;
	assign in_window = (offset >> ADDR_WIDTH) == '0;
	assign local_addr = offset[ADDR_WIDTH-1:0] & ~ADDR_WIDTH'(size_mask(size));

	// Aligned accesses never cross a doubleword
	assign word = words[local_addr[ADDR_WIDTH-1:3]];
	assign read_data = in_window ? zero_extend(word >> {local_addr[2:0], 3'b000}, size) : '0;
endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath import legv8_pkg::*; #(
	parameter logic [ADDR_WIDTH-1:0] PC_RESET_VALUE = '0
) (
	input logic clock,
	input logic reset,
	input logic as,
	input logic [1:0] ds,
	input logic [1:0] ps,
	input logic pcsel,
	input logic bsel,
	input logic il,
	input logic sl,
	input logic [FS_WIDTH-1:0] fs,
	input logic c0,
	input logic rw,
	input logic [REG_SEL_WIDTH-1:0] da,
	input logic [REG_SEL_WIDTH-1:0] sa,
	input logic [REG_SEL_WIDTH-1:0] sb,
	input logic [DATA_WIDTH-1:0] constant,
	input logic [DATA_WIDTH-1:0] mem_data,
	output logic [ADDR_WIDTH-1:0] address,
	output logic [DATA_WIDTH-1:0] data_bus,
	output logic [DATA_WIDTH-1:0] write_data,
	output logic [3:0] status,
	output logic [31:0] ir_out,
	output logic [3:0] sr_out,
	output logic [15:0] r0, r1, r2, r3, r4, r5, r6, r7
);
	logic [DATA_WIDTH-1:0] a_value;
	logic [DATA_WIDTH-1:0] b_reg;
	logic [DATA_WIDTH-1:0] operand_b;
	logic [DATA_WIDTH-1:0] alu_result;
	logic [3:0] alu_flags;
	logic [ADDR_WIDTH-1:0] pc;
	logic [ADDR_WIDTH-1:0] branch_offset;
	logic [7:0][15:0] view;

	// Write-back always comes from the data bus
	register_file reg_file_inst (.clock(clock), .reset(reset), .rw(rw), .da(da), .sa(sa),
		.sb(sb), .write_value(data_bus), .a_value(a_value), .b_value(b_reg), .view(view));

	// Immediate or register for B
	assign operand_b = bsel ? constant : b_reg;

	alu alu_inst (.a(a_value), .b(operand_b), .fs(fs), .c0(c0), .result(alu_result),
		.flags(alu_flags));

	// Branch offset from constant, or from A when pcsel is set
	assign branch_offset = pcsel ? a_value[ADDR_WIDTH-1:0] : constant[ADDR_WIDTH-1:0];

	program_counter #(.RESET_VALUE(PC_RESET_VALUE)) pc_inst (.clock(clock), .reset(reset),
		.ps(ps), .jump_target(a_value[ADDR_WIDTH-1:0]), .offset(branch_offset), .pc(pc));

	// Address bus mux
	assign address = (as == AS_PC) ? pc : alu_result[ADDR_WIDTH-1:0];

	// Data bus mux
	always_comb begin
		case (ds)
			DS_ALU: data_bus = alu_result;
			DS_B: data_bus = operand_b;
			DS_PC: data_bus = DATA_WIDTH'(pc);
			DS_MEM: data_bus = mem_data;
			default: data_bus = '0;
		endcase
	end

	// Instruction and status registers
	always_ff @(posedge clock) begin
		if (reset) begin
			ir_out <= '0;
			sr_out <= '0;
		end else begin
			if (il) begin
				ir_out <= data_bus[31:0];
			end
			if (sl) begin
				sr_out <= alu_flags;
			end
		end
	end

	// Store data is operand B
	assign write_data = operand_b;
	assign status = alu_flags;
	assign {r7, r6, r5, r4, r3, r2, r1, r0} = view;

	// Bus select must be driven every cycle once out of reset
	assert property (@(posedge clock) disable iff (reset) !$isunknown(ds))
		else $error("Data bus select is unknown");
endmodule

`default_nettype wire

// ==== design/legv8_datapath_ts.sv ====
`timescale 1ns/1ps
`default_nettype none

module legv8_datapath_ts import legv8_pkg::*; #(
	parameter logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h2000_0000,
	parameter int RAM_ADDR_WIDTH = 10,
	parameter logic [ADDR_WIDTH-1:0] ROM_BASE = 32'h0000_0000,
	parameter int ROM_ADDR_WIDTH = 8,
	parameter logic [ADDR_WIDTH-1:0] PC_RESET_VALUE = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	input logic [CW_WIDTH-1:0] control_word,
	input logic [DATA_WIDTH-1:0] constant,
	output logic [ADDR_WIDTH-1:0] address,
	output logic [DATA_WIDTH-1:0] data_bus,
	output logic [3:0] status,
	output logic [31:0] ir_out,
	output logic [3:0] sr_out,
	output logic [15:0] r0, r1, r2, r3, r4, r5, r6, r7
);
	// Control word fields
	logic as;
	logic [1:0] ds;
	logic [1:0] ps;
	logic pcsel, bsel, il, sl;
	logic [FS_WIDTH-1:0] fs;
	logic c0;
	logic [1:0] size;
	logic mw, rw;
	logic [REG_SEL_WIDTH-1:0] da, sa, sb;
	// Memory side
	logic [DATA_WIDTH-1:0] write_data;
	logic [DATA_WIDTH-1:0] ram_data;
	logic [DATA_WIDTH-1:0] rom_data;
	logic [DATA_WIDTH-1:0] mem_data;

	// MSB first, as | ds | ps | pcsel | bsel | il | sl | fs | c0 | size | mw | rw | da | sa | sb
	assign {as, ds, ps, pcsel, bsel, il, sl, fs, c0, size, mw, rw, da, sa, sb} = control_word;

	datapath #(.PC_RESET_VALUE(PC_RESET_VALUE)) datapath_inst (.clock(clock), .reset(reset),
		.as(as), .ds(ds), .ps(ps), .pcsel(pcsel), .bsel(bsel), .il(il), .sl(sl), .fs(fs),
		.c0(c0), .rw(rw), .da(da), .sa(sa), .sb(sb), .constant(constant),
		.mem_data(mem_data), .address(address), .data_bus(data_bus),
		.write_data(write_data), .status(status), .ir_out(ir_out), .sr_out(sr_out),
		.r0(r0), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .r5(r5), .r6(r6), .r7(r7));

	// RAM gets the ROM bounds for its write check
	data_memory #(.BASE_ADDR(RAM_BASE), .ADDR_WIDTH(RAM_ADDR_WIDTH), .ROM_BASE(ROM_BASE),
		.ROM_ADDR_WIDTH(ROM_ADDR_WIDTH)) ram_inst (.clock(clock), .address(address),
		.write_data(write_data), .mw(mw), .size(size), .read_data(ram_data));

	instruction_rom #(.BASE_ADDR(ROM_BASE), .ADDR_WIDTH(ROM_ADDR_WIDTH)) rom_inst (
		.address(address), .size(size), .read_data(rom_data));

	// Each memory reads zero outside its window, so OR merges them
	assign mem_data = ram_data | rom_data;
endmodule

`default_nettype wire

// ==== verification/tb_legv8_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_legv8_datapath import legv8_pkg::*; ();
	// Memory map as set by the DUT defaults
	localparam logic [31:0] RAM_BASE = 32'h2000_0000;
	localparam int RAM_BYTES = 1024;
	localparam int ROM_BYTES = 256;
	localparam int FILL_DWORDS = RAM_BYTES / 8;
	localparam int ROM_DWORDS = ROM_BYTES / 8;
	// Run length and the limit derived from it
	localparam int RESET_CYCLES = 3;
	localparam int DIRECTED_CYCLES = 5 + FILL_DWORDS + ROM_DWORDS;
	localparam int RANDOM_CYCLES = 4000;
	localparam int TIMEOUT_CYCLES = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 6 / 5;

	logic clock;
	logic reset;
	logic [CW_WIDTH-1:0] control_word;
	logic [DATA_WIDTH-1:0] constant;
	logic [ADDR_WIDTH-1:0] address;
	logic [DATA_WIDTH-1:0] data_bus;
	logic [3:0] status;
	logic [31:0] ir_out;
	logic [3:0] sr_out;
	logic [15:0] r0, r1, r2, r3, r4, r5, r6, r7;
	logic [7:0][15:0] dut_view;

	// Control fields packed into control_word at each drive
	logic cw_as, cw_pcsel, cw_bsel, cw_il, cw_sl, cw_c0, cw_mw, cw_rw;
	logic [1:0] cw_ds, cw_ps, cw_size;
	logic [FS_WIDTH-1:0] cw_fs;
	logic [REG_SEL_WIDTH-1:0] cw_da, cw_sa, cw_sb;

	// Reference model state
	logic [DATA_WIDTH-1:0] m_regs [0:31];
	logic [ADDR_WIDTH-1:0] m_pc;
	logic [31:0] m_ir;
	logic [3:0] m_sr;
	logic [7:0] m_ram [0:RAM_BYTES-1];
	logic [DATA_WIDTH-1:0] m_rom [0:ROM_DWORDS-1];
	// Model outputs for the current fields
	logic [DATA_WIDTH-1:0] exp_a, exp_b, exp_result, exp_bus;
	logic [3:0] exp_flags;
	logic [ADDR_WIDTH-1:0] exp_address;
	logic [31:0] rng_state;
	int cycle_count = 0;

	legv8_datapath_ts legv8_datapath_ts_inst (.clock(clock), .reset(reset),
		.control_word(control_word), .constant(constant), .address(address),
		.data_bus(data_bus), .status(status), .ir_out(ir_out), .sr_out(sr_out),
		.r0(r0), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .r5(r5), .r6(r6), .r7(r7));

	assign dut_view = {r7, r6, r5, r4, r3, r2, r1, r0};

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Hard stop in case the run never reaches its end
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// XZR reads zero
	function automatic logic [DATA_WIDTH-1:0] register_value(input logic [4:0] sel);
		return (sel == 5'd31) ? '0 : m_regs[sel];
	endfunction

	// RAM contents for the fill depend on every address bit
	function automatic logic [DATA_WIDTH-1:0] fill_pattern(input logic [31:0] addr);
		return {addr * 32'h9e37_79b9, addr ^ 32'h5a5a_c3c3};
	endfunction

	// Little endian read aligned down, zero above the access and outside both windows
	function automatic logic [DATA_WIDTH-1:0] read_memory(input logic [31:0] addr,
		input logic [1:0] size);
		logic [31:0] ram_off;
		logic [DATA_WIDTH-1:0] value;
		int nbytes;
		int start;
		value = '0;
		nbytes = 1 << size;
		ram_off = addr - RAM_BASE;
		if (ram_off < RAM_BYTES) begin
			start = int'(ram_off) & ~(nbytes - 1);
			for (int i = 0; i < nbytes; i++) begin
				value[8*i +: 8] = m_ram[start + i];
			end
		end else if (addr < ROM_BYTES) begin
			start = int'(addr) & ~(nbytes - 1);
			for (int i = 0; i < nbytes; i++) begin
				value[8*i +: 8] = m_rom[(start + i) >> 3][8*((start + i) & 7) +: 8];
			end
		end
		return value;
	endfunction

	task automatic evaluate_model();
		logic [DATA_WIDTH-1:0] a_in;
		logic [DATA_WIDTH-1:0] b_in;
		logic [DATA_WIDTH:0] wide;
		exp_a = register_value(cw_sa);
		exp_b = cw_bsel ? constant : register_value(cw_sb);
		a_in = cw_fs[1] ? ~exp_a : exp_a;
		b_in = cw_fs[0] ? ~exp_b : exp_b;
		// V and C only come from the adder
		exp_flags[3:2] = 2'b00;
		case (cw_fs[4:2])
			FN_AND: exp_result = a_in & b_in;
			FN_OR: exp_result = a_in | b_in;
			FN_ADD: begin
				wide = {1'b0, a_in} + {1'b0, b_in} + 65'(cw_c0);
				exp_result = wide[63:0];
				exp_flags[2] = wide[64];
				// Same operand signs and a different sum sign
				exp_flags[3] = ~(a_in[63] ^ b_in[63]) & (a_in[63] ^ wide[63]);
			end
			FN_XOR: exp_result = a_in ^ b_in;
			FN_LSL: exp_result = a_in << b_in[5:0];
			FN_LSR: exp_result = a_in >> b_in[5:0];
			default: exp_result = '0;
		endcase
		exp_flags[1] = exp_result[63];
		exp_flags[0] = (exp_result == '0);
		exp_address = cw_as ? m_pc : exp_result[31:0];
		case (cw_ds)
			DS_ALU: exp_bus = exp_result;
			DS_B: exp_bus = exp_b;
			DS_PC: exp_bus = {32'd0, m_pc};
			default: exp_bus = read_memory(exp_address, cw_size);
		endcase
	endtask

	// Everything the rising edge changes
	task automatic step_model();
		logic [31:0] ram_off;
		int nbytes;
		int start;
		nbytes = 1 << cw_size;
		ram_off = exp_address - RAM_BASE;
		if (cw_mw && ram_off < RAM_BYTES) begin
			start = int'(ram_off) & ~(nbytes - 1);
			for (int i = 0; i < nbytes; i++) begin
				m_ram[start + i] = exp_b[8*i +: 8];
			end
		end
		if (cw_rw && cw_da != 5'd31) begin
			m_regs[cw_da] = exp_bus;
		end
		if (cw_il) begin
			m_ir = exp_bus[31:0];
		end
		if (cw_sl) begin
			m_sr = exp_flags;
		end
		case (cw_ps)
			PS_INC: m_pc = m_pc + 32'd4;
			PS_JUMP: m_pc = exp_a[31:0];
			// Word offset from the constant or from A
			PS_BRANCH: m_pc = m_pc + ((cw_pcsel ? exp_a[31:0] : constant[31:0]) << 2);
			default: m_pc = m_pc;
		endcase
	endtask

	task automatic compare_signal(input string name, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] expected);
		assert (got === expected) else begin
			$display("MISMATCH %s: dut=%h expected=%h", name, got, expected);
			$display("test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic compare_outputs();
		compare_signal("address", 64'(address), 64'(exp_address));
		compare_signal("data_bus", data_bus, exp_bus);
		compare_signal("status", 64'(status), 64'(exp_flags));
		compare_signal("ir_out", 64'(ir_out), 64'(m_ir));
		compare_signal("sr_out", 64'(sr_out), 64'(m_sr));
		for (int i = 0; i < 8; i++) begin
			compare_signal($sformatf("r%0d", i), 64'(dut_view[i]), 64'(m_regs[i][15:0]));
		end
	endtask

	// Idle word with both operands from XZR
	task automatic clear_fields();
		{cw_as, cw_ds, cw_ps, cw_pcsel, cw_bsel, cw_il, cw_sl, cw_c0} = '0;
		{cw_fs, cw_size, cw_mw, cw_rw, cw_da} = '0;
		cw_sa = 5'd31;
		cw_sb = 5'd31;
		constant = '0;
	endtask

	// Called at a falling edge and returns at the next one
	task automatic run_cycle();
		control_word = {cw_as, cw_ds, cw_ps, cw_pcsel, cw_bsel, cw_il, cw_sl, cw_fs, cw_c0,
			cw_size, cw_mw, cw_rw, cw_da, cw_sa, cw_sb};
		#1;
		evaluate_model();
		compare_outputs();
		step_model();
		@(negedge clock);
	endtask

	task automatic randomize_fields();
		logic [31:0] r;
		logic [31:0] target;
		r = next_random();
		cw_as = r[0];
		cw_ds = r[2:1];
		cw_ps = r[4:3];
		cw_pcsel = r[5];
		cw_bsel = r[6];
		cw_il = r[7];
		cw_sl = r[8];
		cw_c0 = r[9];
		cw_size = r[11:10];
		cw_mw = r[12];
		cw_rw = r[13];
		cw_da = r[18:14];
		cw_sa = r[23:19];
		cw_sb = r[28:24];
		// Only the six defined operations
		cw_fs = {3'(next_random() % 6), r[30:29]};
		constant[63:32] = next_random();
		constant[31:0] = next_random();
		r = next_random();
		// Most cycles steer the ALU result into a memory window
		if (r[2:0] < 3'd5) begin
			target = r[3] ? RAM_BASE + (32'(r[31:16]) % RAM_BYTES) : 32'(r[31:16]) % ROM_BYTES;
			cw_as = AS_ALU;
			cw_fs = {FN_ADD, 2'b00};
			cw_c0 = 1'b0;
			cw_bsel = 1'b1;
			// A plus constant hits the target and the store data varies with A
			constant = {32'd0, target} - register_value(cw_sa);
			if (r[4]) begin
				cw_ds = DS_MEM;
			end
		end
		evaluate_model();
		// No stores into the ROM window
		if (exp_address < ROM_BYTES) begin
			cw_mw = 1'b0;
		end
		// Jumps only to word aligned targets so the PC stays aligned
		if (cw_ps == PS_JUMP && exp_a[1:0] != 2'b00) begin
			cw_ps = PS_HOLD;
		end
	endtask

	initial begin
		rng_state = 32'h1934_37f8;
		reset = 1'b1;
		clear_fields();
		control_word = '0;
		$readmemh("verification/rom_image.hex", m_rom);
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		m_pc = '0;
		m_ir = '0;
		m_sr = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;

		// PC on the address bus right after reset
		clear_fields();
		cw_as = AS_PC;
		run_cycle();
		compare_signal("address", 64'(address), 64'd0);
		compare_signal("ir_out", 64'(ir_out), 64'd0);
		compare_signal("sr_out", 64'(sr_out), 64'd0);
		compare_signal("r0..r3", 64'(dut_view[3:0]), 64'd0);
		compare_signal("r4..r7", 64'(dut_view[7:4]), 64'd0);

		// X3 = 2 for an 8 byte branch step and X4 = RAM base
		clear_fields();
		cw_bsel = 1'b1;
		cw_fs = {FN_OR, 2'b00};
		cw_rw = 1'b1;
		cw_da = 5'd3;
		constant = 64'd2;
		run_cycle();
		cw_da = 5'd4;
		constant = {32'd0, RAM_BASE};
		run_cycle();
		clear_fields();
		cw_ps = PS_JUMP;
		cw_sa = 5'd4;
		run_cycle();

		// Fill the RAM through the PC with one doubleword per cycle
		for (int i = 0; i < FILL_DWORDS; i++) begin
			clear_fields();
			cw_as = AS_PC;
			cw_ps = PS_BRANCH;
			cw_pcsel = 1'b1;
			cw_sa = 5'd3;
			cw_bsel = 1'b1;
			cw_mw = 1'b1;
			cw_size = SIZE_DOUBLE;
			constant = fill_pattern(RAM_BASE + 32'(8 * i));
			run_cycle();
		end

		// Back to zero and then walk the ROM into IR and X0..X7
		clear_fields();
		cw_ps = PS_JUMP;
		run_cycle();
		for (int i = 0; i < ROM_DWORDS; i++) begin
			clear_fields();
			cw_as = AS_PC;
			cw_ds = DS_MEM;
			cw_size = SIZE_DOUBLE;
			cw_ps = PS_BRANCH;
			cw_pcsel = 1'b1;
			cw_sa = 5'd3;
			cw_il = 1'b1;
			cw_rw = 1'b1;
			cw_da = 5'(i % 8);
			run_cycle();
		end

		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			randomize_fields();
			run_cycle();
		end

		$display("test passed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== verification/rom_image.hex ====
// One 64-bit doubleword per line, doubleword 0 first, byte 0 in the two rightmost digits
8b020020_91001001
d2800fe1_f8400022
cb010043_aa0300a4
8a050086_ca0700e8
d3400d29_d340fd4a
b400004b_f800012c
17fffffd_d61f0200
91002108_eb09011f
54000041_d2800000
f8408101_f8008102
9100a3e3_cb1f03e4
aa1f03e5_8b0500a6
d37ff8c7_d341fce8
b5ffffe9_1400000a
de1c4a2f_0f3b7e61
5a5ac3c3_a5a53c3c
13579bdf_2468ace0
fedcba98_76543210
0123ff00_00ff3210
80000000_00000001
7fffffff_ffffffff
00000000_80000000
ffff0000_0000ffff
c0ffee11_badd00d5
9e3779b9_7f4a7c15
31415926_53589793
27182818_28459045
abcdef01_23456789
11223344_55667788
99aabbcc_ddeeff00
0f1e2d3c_4b5a6978
e1d2c3b4_a5968778

// ==== files.f ====
design/legv8_pkg.sv
design/register_file.sv
design/alu.sv
design/program_counter.sv
design/data_memory.sv
design/instruction_rom.sv
design/datapath.sv
design/legv8_datapath_ts.sv
verification/tb_legv8_datapath.sv

// ==== Makefile ====
SIM := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP := tb_legv8_datapath
FILE_LIST := files.f
BUILD_DIR := obj_dir
SIM_BIN := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
